//--- monopix.f
source/confPkg.sv
source/readoutPkg.sv
source/confShiftReg.sv
source/matrixPeriphery.sv
source/flavorReadout.sv
source/monopixCore.sv
sim/readoutChecker.sv
sim/monopixTb.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = monopixTb
FILELIST = monopix.f

SRCS = $(shell cat $(FILELIST))
BIN  = obj_dir/$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -o $(TOP)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; \
	echo "$$out" | grep -q "Test completed successfully"

clean:
	rm -rf obj_dir

//--- sim/monopixTb.sv
`timescale 1ns/1ps

module monopixTb;

    localparam int NumFlavors = 2;
    localparam int NumCols = 4;
    localparam int ConfBits = 28;
    localparam int WordBits = 8;
    localparam real ClkPeriod = 40.0;
    localparam int Timeout = 40;
    localparam int NumRows = 7;
    localparam logic [5:0] TestStamp = 6'b101010;

    logic       ClkBx = 1'b0;
    logic       reset_ff = 1'b1;
    logic       ClkConf = 1'b0;
    logic       SiConf = 1'b0;
    logic       LdConf = 1'b0;
    logic       DefConf = 1'b0;
    logic       SoConf;
    logic       ResetBcid = 1'b0;
    logic       Pulse = 1'b0;
    logic [7:0] Hits = '0;
    logic [1:0] Freeze = '0;
    logic [1:0] Read = '0;
    logic [1:0] Token;
    logic [1:0] DataOut;
    logic [1:0] OutValid;
    logic [1:0] HitOr;

    // Stimulus table
    string      rowName [NumRows];
    logic [1:0] rowTp [NumRows];
    logic [1:0] rowEn [NumRows];
    logic [7:0] rowPulseSel [NumRows];
    logic [7:0] rowMask [NumRows];
    logic [7:0] rowMonSel [NumRows];
    logic [7:0] rowHitsA [NumRows];
    logic [7:0] rowHitsB [NumRows];
    logic       rowPulseA [NumRows];
    int         rowGap [NumRows];
    logic [1:0] rowFreeze [NumRows];

    always #(ClkPeriod / 2) ClkBx = ~ClkBx;

    monopixCore #(.NumFlavors(NumFlavors), .NumCols(NumCols)) dut0 (
        .ClkBx(ClkBx), .reset_ff(reset_ff), .ClkConf(ClkConf), .SiConf(SiConf),
        .LdConf(LdConf), .DefConf(DefConf), .SoConf(SoConf), .ResetBcid(ResetBcid),
        .Pulse(Pulse), .Hits(Hits), .Freeze(Freeze), .Read(Read), .Token(Token),
        .DataOut(DataOut), .OutValid(OutValid), .HitOr(HitOr)
    );

    readoutChecker #(.NumFlavors(NumFlavors), .WordBits(WordBits)) checker0 (
        .ClkBx(ClkBx), .reset_ff(reset_ff), .Token(Token), .DataOut(DataOut),
        .OutValid(OutValid), .HitOr(HitOr)
    );

    task automatic setRow(input int r, input string name, input logic [1:0] tp,
                          input logic [1:0] en, input logic [7:0] pulseSel,
                          input logic [7:0] mask, input logic [7:0] monSel,
                          input logic [7:0] hitsA, input logic pulseA,
                          input logic [7:0] hitsB, input int gap, input logic [1:0] frz);
        rowName[r] = name;
        rowTp[r] = tp;
        rowEn[r] = en;
        rowPulseSel[r] = pulseSel;
        rowMask[r] = mask;
        rowMonSel[r] = monSel;
        rowHitsA[r] = hitsA;
        rowPulseA[r] = pulseA;
        rowHitsB[r] = hitsB;
        rowGap[r] = gap;
        rowFreeze[r] = frz;
    endtask

    task automatic fillTable();
        setRow(0, "twoColumns", 2'b00, 2'b11, 8'h00, 8'hff, 8'h00, 8'h14, 0, 8'h82, 5, 2'b00);
        setRow(1, "maskedCol", 2'b00, 2'b11, 8'h00, 8'hfe, 8'h00, 8'h01, 0, 8'h00, 3, 2'b00);
        setRow(2, "flavorOff", 2'b00, 2'b01, 8'h00, 8'hff, 8'h00, 8'h30, 0, 8'h00, 3, 2'b00);
        setRow(3, "freeze", 2'b00, 2'b11, 8'h00, 8'hff, 8'h00, 8'h11, 0, 8'h00, 3, 2'b11);
        setRow(4, "pulseInject", 2'b00, 2'b11, 8'h48, 8'hff, 8'hff, 8'h00, 1, 8'h00, 2, 2'b00);
        setRow(5, "testPattern", 2'b11, 2'b11, 8'h00, 8'hff, 8'h01, 8'h03, 0, 8'h80, 40, 2'b00);
        setRow(6, "monitorSel", 2'b00, 2'b11, 8'h00, 8'hff, 8'h20, 8'h22, 0, 8'h01, 70, 2'b00);
    endtask

    // Serial order: test pattern, flavor enable, pulse select, mask, monitor select
    function automatic logic [ConfBits-1:0] makeImage(logic [1:0] tp, logic [1:0] en,
            logic [7:0] pulseSel, logic [7:0] mask, logic [7:0] monSel);
        return {monSel, mask, pulseSel, en, tp};
    endfunction

    function automatic logic [5:0] grayDecode(logic [5:0] g);
        logic [5:0] bin;
        for (int i = 0; i < 6; i++) begin
            bin[i] = ^(g >> i);
        end
        return bin;
    endfunction

    function automatic logic [7:0] gateCols(int r, logic [7:0] hits, logic pulse);
        logic [7:0] flavorEn;
        flavorEn = {{4{rowEn[r][1]}}, {4{rowEn[r][0]}}};
        return (hits | (pulse ? rowPulseSel[r] : 8'h00)) & rowMask[r] & flavorEn;
    endfunction

    // Bit i goes out before the edge that shifts in[i]
    task automatic shiftImage(input logic [ConfBits-1:0] in, output logic [ConfBits-1:0] out);
        for (int i = 0; i < ConfBits; i++) begin
            out[i] = SoConf;
            SiConf = in[i];
            repeat (3) @(negedge ClkBx);
            ClkConf = 1'b1;
            repeat (3) @(negedge ClkBx);
            ClkConf = 1'b0;
        end
        repeat (3) @(negedge ClkBx);
    endtask

    task automatic loadConf(input logic [ConfBits-1:0] img);
        logic [ConfBits-1:0] dummy;
        shiftImage(img, dummy);
        LdConf = 1'b1;
        @(negedge ClkBx);
        LdConf = 1'b0;
        @(negedge ClkBx);
    endtask

    task automatic waitToken(input int f, input logic level, input string name);
        for (int i = 0; i < Timeout && Token[f] !== level; i++) begin
            @(negedge ClkBx);
        end
        if (Token[f] !== level) begin
            checker0.reportFailure($sformatf("Token of flavor %0d stuck at %b in %s",
                                             f, Token[f], name));
        end
    endtask

    task automatic readWord(input int f, input string name);
        int cnt0;
        cnt0 = checker0.wordCount[f];
        Read[f] = 1'b1;
        for (int i = 0; i < Timeout && checker0.wordCount[f] == cnt0; i++) begin
            @(negedge ClkBx);
        end
        if (checker0.wordCount[f] == cnt0) begin
            checker0.reportFailure($sformatf("No word from flavor %0d in %s", f, name));
        end
        Read[f] = 1'b0;
        @(negedge ClkBx);
    endtask

    task automatic checkSilent(input int f, input string name);
        for (int i = 0; i < 4; i++) begin
            @(negedge ClkBx);
            checker0.checkToken($sformatf("%s f%0d token", name, f), f, 1'b0);
        end
        Read[f] = 1'b1;   // Nothing stored, so no word may follow
        for (int i = 0; i < 14; i++) begin
            @(negedge ClkBx);
            if (OutValid[f]) begin
                checker0.reportFailure($sformatf("Flavor %0d sent a word with nothing stored in %s",
                                                 f, name));
                break;
            end
        end
        Read[f] = 1'b0;
        @(negedge ClkBx);
    endtask

    task automatic runRow(input int r);
        logic [7:0] gA;
        logic [7:0] gB;
        logic [7:0] stored;
        logic [7:0] phaseB;
        logic [3:0] colSet;
        logic [7:0] w;
        logic [5:0] refA;
        logic [5:0] off;
        logic [1:0] expHitOr;
        int         c;
        bit         first;
        gA = gateCols(r, rowHitsA[r], rowPulseA[r]);
        gB = gateCols(r, rowHitsB[r], 1'b0);
        stored = rowFreeze[r] != 0 ? 8'h00 : (gA | gB);
        phaseB = gB & ~gA;
        for (int f = 0; f < NumFlavors; f++) begin
            expHitOr[f] = |(gA[f*4 +: 4] & rowMonSel[r][f*4 +: 4]);
        end
        loadConf(makeImage(rowTp[r], rowEn[r], rowPulseSel[r], rowMask[r], rowMonSel[r]));
        Freeze = rowFreeze[r];
        @(negedge ClkBx);
        Hits = rowHitsA[r];
        Pulse = rowPulseA[r];
        @(negedge ClkBx);
        checker0.checkHitOr({rowName[r], " hitOr"}, expHitOr);
        Hits = '0;
        Pulse = 1'b0;
        repeat (rowGap[r] - 1) @(negedge ClkBx);
        Hits = rowHitsB[r];
        @(negedge ClkBx);
        Hits = '0;
        repeat (2) @(negedge ClkBx);
        Freeze = '0;
        for (int f = 0; f < NumFlavors; f++) begin
            colSet = stored[f*4 +: 4];
            if (colSet == 0) begin
                checkSilent(f, rowName[r]);
                continue;
            end
            waitToken(f, 1'b1, rowName[r]);
            first = 1'b1;
            while (colSet != 0) begin
                c = 0;
                for (int k = 0; k < 4; k++) begin
                    if (colSet[k]) begin
                        c = k;
                        break;
                    end
                end
                readWord(f, rowName[r]);
                w = checker0.lastWord[f];
                checker0.checkValue($sformatf("%s f%0d addr", rowName[r], f), c, w[7:6]);
                off = phaseB[f*4 + c] ? 6'(rowGap[r]) : 6'd0;
                if (rowTp[r][f]) begin
                    checker0.checkValue($sformatf("%s f%0d stamp", rowName[r], f),
                                        TestStamp, w[5:0]);
                end else if (first) begin
                    refA = grayDecode(w[5:0]) - off;
                end else begin
                    checker0.checkValue($sformatf("%s f%0d bcid", rowName[r], f),
                                        6'(refA + off), grayDecode(w[5:0]));
                end
                first = 1'b0;
                colSet[c] = 1'b0;
            end
            waitToken(f, 1'b0, rowName[r]);
        end
    endtask

    initial begin
        logic [ConfBits-1:0] defImage;
        logic [ConfBits-1:0] img;
        logic [ConfBits-1:0] readBack;
        void'($urandom(32'hc264e5ec));
        fillTable();
        defImage = makeImage(2'b00, 2'b11, 8'h00, 8'hff, 8'h00);
        repeat (8) @(negedge ClkBx);
        reset_ff = 1'b0;
        @(negedge ClkBx);
        for (int f = 0; f < NumFlavors; f++) begin
            checker0.checkToken($sformatf("reset token f%0d", f), f, 1'b0);
        end
        checker0.checkValue("reset outValid", 0, OutValid);
        checker0.checkValue("reset dataOut", 0, DataOut);
        checker0.checkHitOr("reset hitOr", 2'b00);
        shiftImage(defImage, readBack);
        checker0.checkValue("default image", defImage, readBack);

        img = ConfBits'($urandom);
        loadConf(img);
        shiftImage(img, readBack);
        checker0.checkValue("round trip", img, readBack);
        DefConf = 1'b1;
        @(negedge ClkBx);
        DefConf = 1'b0;
        @(negedge ClkBx);
        shiftImage(defImage, readBack);
        checker0.checkValue("default restore", defImage, readBack);

        for (int r = 0; r < NumRows; r++) begin
            runRow(r);
        end

        $display("Errors: %0d value, %0d other", checker0.valueErrors, checker0.otherErrors);
        if (checker0.valueErrors == 0 && checker0.otherErrors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // Guards against a stuck run
    initial begin
        #(ClkPeriod * 100000);
        $display("Simulation ran too long and was stopped");
        $display("Test failed");
        $finish;
    end

endmodule

//--- sim/readoutChecker.sv
`timescale 1ns/1ps

module readoutChecker #(
    parameter int NumFlavors = 2,
    parameter int WordBits = 8
) (
    input  logic                  ClkBx,
    input  logic                  reset_ff,
    input  logic [NumFlavors-1:0] Token,
    input  logic [NumFlavors-1:0] DataOut,
    input  logic [NumFlavors-1:0] OutValid,
    input  logic [NumFlavors-1:0] HitOr
);

    int valueErrors = 0;
    int otherErrors = 0;

    int                  wordCount [NumFlavors];   // Words seen per flavor
    logic [WordBits-1:0] lastWord [NumFlavors];
    logic [WordBits-1:0] curWord [NumFlavors];
    int                  curLen [NumFlavors];

    initial begin
        for (int f = 0; f < NumFlavors; f++) begin
            wordCount[f] = 0;
            lastWord[f] = '0;
            curWord[f] = '0;
            curLen[f] = 0;
        end
    end

    task automatic checkValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        if (expected !== actual) begin
            $display("ERROR %s expected 0x%0h actual 0x%0h", name, expected, actual);
            valueErrors++;
        end
    endtask

    task automatic reportFailure(input string what);
        $display("%s", what);
        otherErrors++;
    endtask

    // Token line of one flavor against its expected level
    task automatic checkToken(input string name, input int f, input logic expected);
        checkValue(name, expected, Token[f]);
    endtask

    task automatic checkHitOr(input string name, input logic [NumFlavors-1:0] expected);
        checkValue(name, expected, HitOr);
    endtask

    // Assemble serial words, MSB first
    always @(posedge ClkBx) begin
        if (!reset_ff) begin
            for (int f = 0; f < NumFlavors; f++) begin
                if (OutValid[f]) begin
                    curWord[f] = {curWord[f][WordBits-2:0], DataOut[f]};
                    curLen[f]++;
                end else if (curLen[f] != 0) begin
                    if (curLen[f] != WordBits) begin
                        reportFailure($sformatf("Flavor %0d sent a word of %0d bits", f,
                                                curLen[f]));
                    end
                    lastWord[f] = curWord[f];
                    wordCount[f]++;
                    curLen[f] = 0;
                end
            end
        end
    end

endmodule

//--- source/monopixCore.sv
`timescale 1ns/1ps

module monopixCore import confPkg::*, readoutPkg::*; #(
    parameter int NumFlavors = 2,
    parameter int NumCols = 4
) (
    input  logic                          ClkBx,
    input  logic                          reset_ff,
    input  logic                          ClkConf,
    input  logic                          SiConf,
    input  logic                          LdConf,
    input  logic                          DefConf,
    output logic                          SoConf,
    input  logic                          ResetBcid,
    input  logic                          Pulse,
    input  logic [NumFlavors*NumCols-1:0] Hits,
    input  logic [NumFlavors-1:0]         Freeze,
    input  logic [NumFlavors-1:0]         Read,
    output logic [NumFlavors-1:0]         Token,
    output logic [NumFlavors-1:0]         DataOut,
    output logic [NumFlavors-1:0]         OutValid,
    output logic [NumFlavors-1:0]         HitOr
);

    localparam int ConfBits = NumFlavors * (ConfBitsPerFlavor + ConfBitsPerCol * NumCols);
    localparam int NumColsAll = NumFlavors * NumCols;

    // Field positions in the active image
    localparam int OffEnTestPattern = fieldOffset(FieldEnTestPattern, NumFlavors, NumCols);
    localparam int OffEnFlavor = fieldOffset(FieldEnFlavor, NumFlavors, NumCols);
    localparam int OffColPulseSel = fieldOffset(FieldColPulseSel, NumFlavors, NumCols);
    localparam int OffColMask = fieldOffset(FieldColMask, NumFlavors, NumCols);
    localparam int OffDigMonSel = fieldOffset(FieldDigMonSel, NumFlavors, NumCols);

    logic [ConfBits-1:0]   confImage;
    logic [NumColsAll-1:0] colHits;
    logic [BcidBits-1:0]   bcid;        // Gray timestamp shared by all flavors

    confShiftReg #(
        .NumFlavors(NumFlavors),
        .NumCols(NumCols),
        .ConfBits(ConfBits)
    ) confReg0 (
        .ClkBx(ClkBx),
        .reset_ff(reset_ff),
        .ClkConf(ClkConf),
        .SiConf(SiConf),
        .LdConf(LdConf),
        .DefConf(DefConf),
        .SoConf(SoConf),
        .ConfOut(confImage)
    );

    matrixPeriphery #(
        .NumFlavors(NumFlavors),
        .NumCols(NumCols)
    ) periphery0 (
        .ClkBx(ClkBx),
        .reset_ff(reset_ff),
        .ResetBcid(ResetBcid),
        .Pulse(Pulse),
        .Hits(Hits),
        .EnFlavor(confImage[OffEnFlavor +: NumFlavors]),
        .ColPulseSel(confImage[OffColPulseSel +: NumColsAll]),
        .ColMask(confImage[OffColMask +: NumColsAll]),
        .DigMonSel(confImage[OffDigMonSel +: NumColsAll]),
        .ColHits(colHits),
        .Bcid(bcid),
        .HitOr(HitOr)
    );

    for (genvar f = 0; f < NumFlavors; f++) begin : genFlavor
        flavorReadout #(
            .NumCols(NumCols)
        ) readout0 (
            .ClkBx(ClkBx),
            .reset_ff(reset_ff),
            .ColHits(colHits[f*NumCols +: NumCols]),
            .Bcid(bcid),
            .Freeze(Freeze[f]),
            .Read(Read[f]),
            .EnTestPattern(confImage[OffEnTestPattern + f]),
            .Token(Token[f]),
            .DataOut(DataOut[f]),
            .OutValid(OutValid[f])
        );
    end

endmodule

//--- source/flavorReadout.sv
`timescale 1ns/1ps

module flavorReadout import readoutPkg::*; #(
    parameter int NumCols = 4
) (
    input  logic                ClkBx,
    input  logic                reset_ff,
    input  logic [NumCols-1:0]  ColHits,
    input  logic [BcidBits-1:0] Bcid,
    input  logic                Freeze,
    input  logic                Read,
    input  logic                EnTestPattern,
    output logic                Token,
    output logic                DataOut,
    output logic                OutValid
);

    localparam int ColAddrBits = (NumCols > 1) ? $clog2(NumCols) : 1;
    localparam int WordBits = hitWordBits(ColAddrBits);
    localparam int CntBits = $clog2(WordBits);

    logic [NumCols-1:0]     storedQ;           // Column holds a hit
    logic [BcidBits-1:0]    stampQ [NumCols];
    logic [NumCols-1:0]     captureEn;
    logic                   anyStored;
    logic                   readQ;
    logic                   readRise;
    logic [ColAddrBits-1:0] lowCol;
    logic                   pendingQ;          // Word load on the next edge
    logic [ColAddrBits-1:0] selColQ;
    logic [WordBits-1:0]    shiftQ;
    logic [CntBits-1:0]     bitCntQ;
    logic                   outValidQ;
    logic                   tokenQ;

    // Empty columns take the first hit unless frozen
    assign captureEn = ColHits & ~storedQ & {NumCols{~Freeze}};
    assign anyStored = |storedQ;
    assign readRise = Read & ~readQ;

    // Priority select, lowest stored column wins
    always_comb begin
        lowCol = '0;
        for (int c = NumCols - 1; c >= 0; c--) begin
            if (storedQ[c]) begin
                lowCol = ColAddrBits'(c);
            end
        end
    end

    always_ff @(posedge ClkBx) begin
        if (reset_ff) begin
            storedQ <= '0;
        end else begin
            for (int c = 0; c < NumCols; c++) begin
                if (captureEn[c]) begin
                    storedQ[c] <= 1'b1;
                end else if (pendingQ && selColQ == ColAddrBits'(c)) begin
                    storedQ[c] <= 1'b0;   // Freed as its word is loaded
                end
            end
        end
    end

    always_ff @(posedge ClkBx) begin
        for (int c = 0; c < NumCols; c++) begin
            if (captureEn[c]) begin
                stampQ[c] <= Bcid;
            end
        end
    end

    always_ff @(posedge ClkBx) begin
        if (reset_ff) begin
            readQ <= 1'b0;
            pendingQ <= 1'b0;
        end else begin
            readQ <= Read;
            // Read edges during a word are dropped
            pendingQ <= readRise && !outValidQ && !pendingQ && anyStored;
        end
    end

    always_ff @(posedge ClkBx) begin
        if (readRise) begin
            selColQ <= lowCol;
        end
    end

    always_ff @(posedge ClkBx) begin
        if (reset_ff) begin
            tokenQ <= 1'b0;
            outValidQ <= 1'b0;
            bitCntQ <= '0;
        end else begin
            tokenQ <= anyStored;
            if (pendingQ) begin
                outValidQ <= 1'b1;
                bitCntQ <= CntBits'(WordBits - 1);
            end else if (outValidQ) begin
                if (bitCntQ == '0) begin
                    outValidQ <= 1'b0;   // Last bit on the line
                end else begin
                    bitCntQ <= bitCntQ - 1'b1;
                end
            end
        end
    end

    always_ff @(posedge ClkBx) begin
        if (pendingQ) begin
            shiftQ <= {selColQ, EnTestPattern ? TestBcid : stampQ[selColQ]};
        end else if (outValidQ) begin
            shiftQ <= shiftQ << 1;
        end
    end

    assign Token = tokenQ;
    assign OutValid = outValidQ;
    assign DataOut = outValidQ & shiftQ[WordBits-1];   // MSB first

    // The column picked at the Read edge must still hold its hit at load
    assert property (@(posedge ClkBx) disable iff (reset_ff)
        pendingQ |-> storedQ[selColQ]);

    assert property (@(posedge ClkBx) disable iff (reset_ff)
        $rose(outValidQ) |-> ##(WordBits - 1) outValidQ ##1 !outValidQ);

endmodule

//--- source/matrixPeriphery.sv
`timescale 1ns/1ps

module matrixPeriphery import readoutPkg::*; #(
    parameter int NumFlavors = 2,
    parameter int NumCols = 4
) (
    input  logic                          ClkBx,
    input  logic                          reset_ff,
    input  logic                          ResetBcid,
    input  logic                          Pulse,
    input  logic [NumFlavors*NumCols-1:0] Hits,
    input  logic [NumFlavors-1:0]         EnFlavor,
    input  logic [NumFlavors*NumCols-1:0] ColPulseSel,
    input  logic [NumFlavors*NumCols-1:0] ColMask,
    input  logic [NumFlavors*NumCols-1:0] DigMonSel,
    output logic [NumFlavors*NumCols-1:0] ColHits,
    output logic [BcidBits-1:0]           Bcid,
    output logic [NumFlavors-1:0]         HitOr
);

    localparam int NumColsAll = NumFlavors * NumCols;

    logic [BcidBits-1:0]   bcidBin;
    logic [NumColsAll-1:0] injHits;    // Discriminator or injected pulse
    logic [NumColsAll-1:0] flavorEn;   // Flavor enable spread over its columns
    logic [NumFlavors-1:0] hitOrNext;

    always_comb begin
        for (int f = 0; f < NumFlavors; f++) begin
            flavorEn[f*NumCols +: NumCols] = {NumCols{EnFlavor[f]}};
        end
    end

    assign injHits = Hits | ({NumColsAll{Pulse}} & ColPulseSel);
    assign ColHits = injHits & ColMask & flavorEn;

    // Monitor OR per flavor over the selected columns
    always_comb begin
        for (int f = 0; f < NumFlavors; f++) begin
            hitOrNext[f] = |(ColHits[f*NumCols +: NumCols] & DigMonSel[f*NumCols +: NumCols]);
        end
    end

    always_ff @(posedge ClkBx) begin
        if (reset_ff || ResetBcid) begin
            bcidBin <= '0;
        end else begin
            bcidBin <= bcidBin + 1'b1;    // Wraps every 64 cycles
        end
    end

    always_ff @(posedge ClkBx) begin
        if (reset_ff) begin
            Bcid <= '0;
            HitOr <= '0;
        end else begin
            Bcid <= binToGray(bcidBin);
            HitOr <= hitOrNext;
        end
    end

    // Timestamp bus flips one bit per cycle, apart from a BCID reset
    assert property (@(posedge ClkBx) disable iff (reset_ff)
        !$past(ResetBcid, 2) && !$past(reset_ff, 2) |-> $countones(Bcid ^ $past(Bcid)) == 1);

endmodule

//--- source/confShiftReg.sv
`timescale 1ns/1ps

module confShiftReg import confPkg::*; #(
    parameter int NumFlavors = 2,
    parameter int NumCols = 4,
    parameter int ConfBits = NumFlavors * (ConfBitsPerFlavor + ConfBitsPerCol * NumCols)
) (
    input  logic                ClkBx,
    input  logic                reset_ff,
    input  logic                ClkConf,
    input  logic                SiConf,
    input  logic                LdConf,
    input  logic                DefConf,
    output logic                SoConf,
    output logic [ConfBits-1:0] ConfOut
);

    function automatic logic [ConfBits-1:0] buildDefault();
        logic [ConfBits-1:0] img;
        int off;
        img = '0;
        for (int f = 0; f < NumConfFields; f++) begin
            off = fieldOffset(confFieldT'(f), NumFlavors, NumCols);
            for (int b = 0; b < fieldWidth(confFieldT'(f), NumFlavors, NumCols); b++) begin
                img[off + b] = fieldDefault(confFieldT'(f));
            end
        end
        return img;
    endfunction

    localparam logic [ConfBits-1:0] DefImage = buildDefault();

    logic                clkConfQ;   // ClkConf seen on ClkBx
    logic                clkConfQQ;
    logic                siConfQ;    // Data bit taken with the edge
    logic                shiftEn;
    logic [ConfBits-1:0] shiftQ;
    logic [ConfBits-1:0] confQ;

    always_ff @(posedge ClkBx) begin
        if (reset_ff) begin
            clkConfQ <= 1'b0;
            clkConfQQ <= 1'b0;
        end else begin
            clkConfQ <= ClkConf;
            clkConfQQ <= clkConfQ;
        end
    end

    always_ff @(posedge ClkBx) begin
        siConfQ <= SiConf;
    end

    assign shiftEn = clkConfQ & ~clkConfQQ; // Rising edge of the slow strobe

    // New bits enter at the top and move down, so the first
    // shifted bit ends at bit 0 after ConfBits edges
    always_ff @(posedge ClkBx) begin
        if (reset_ff || DefConf) begin
            shiftQ <= DefImage;
            confQ <= DefImage;
        end else begin
            if (shiftEn) begin
                shiftQ <= {siConfQ, shiftQ[ConfBits-1:1]};
            end
            if (LdConf) begin
                confQ <= shiftQ;   // Level sensitive, copies every cycle
            end
        end
    end

    assign SoConf = shiftQ[0];
    assign ConfOut = confQ;

    // Active image moves only after a load, a default load or reset
    assert property (@(posedge ClkBx) disable iff (reset_ff)
        !$past(LdConf || DefConf || reset_ff) |-> $stable(ConfOut));

endmodule

//--- source/readoutPkg.sv
package readoutPkg;

    localparam int BcidBits = 6;

    // Stamp sent instead of the BCID in test pattern mode
    localparam logic [BcidBits-1:0] TestBcid = 6'b101010;

    // Hit word layout, sent MSB first:
    //   {column address, Gray BCID}
    // The column address width depends on the column count of the flavor
    function automatic int hitWordBits(int colAddrBits);
        return colAddrBits + BcidBits;
    endfunction

    function automatic logic [BcidBits-1:0] binToGray(logic [BcidBits-1:0] bin);
        return bin ^ (bin >> 1);
    endfunction

    // Decoding side, for whoever unpacks the hit words
    function automatic logic [BcidBits-1:0] grayToBin(logic [BcidBits-1:0] gray);
        logic [BcidBits-1:0] bin;
        bin[BcidBits-1] = gray[BcidBits-1];
        for (int i = BcidBits - 2; i >= 0; i--) begin
            bin[i] = bin[i+1] ^ gray[i];
        end
        return bin;
    endfunction

endpackage

//--- source/confPkg.sv
package confPkg;

    localparam int ConfBitsPerFlavor = 2; // Test pattern and flavor enable
    localparam int ConfBitsPerCol = 3;    // Pulse select, mask, monitor select

    // Serial image order, first shifted field ends at bit 0
    typedef enum int {
        FieldEnTestPattern,
        FieldEnFlavor,
        FieldColPulseSel,
        FieldColMask,
        FieldDigMonSel
    } confFieldT;

    localparam int NumConfFields = 5;

    // One default bit per field, replicated over its width
    localparam logic DefEnTestPattern = 1'b0;
    localparam logic DefEnFlavor = 1'b1;
    localparam logic DefColPulseSel = 1'b0;
    localparam logic DefColMask = 1'b1;       // 1 keeps the column active
    localparam logic DefDigMonSel = 1'b0;

    function automatic int fieldWidth(confFieldT field, int numFlavors, int numCols);
        if (field == FieldEnTestPattern || field == FieldEnFlavor) begin
            return numFlavors;
        end
        return numFlavors * numCols;
    endfunction

    // Sum of the widths of all fields shifted before this one
    function automatic int fieldOffset(confFieldT field, int numFlavors, int numCols);
        int off = 0;
        for (int f = 0; f < int'(field); f++) begin
            off += fieldWidth(confFieldT'(f), numFlavors, numCols);
        end
        return off;
    endfunction

    function automatic logic fieldDefault(confFieldT field);
        case (field)
            FieldEnTestPattern: return DefEnTestPattern;
            FieldEnFlavor:      return DefEnFlavor;
            FieldColPulseSel:   return DefColPulseSel;
            FieldColMask:       return DefColMask;
            default:            return DefDigMonSel;
        endcase
    endfunction

endpackage
